// File: project.f
+incdir+src
src/cfg_pkg.sv
src/tlb_pkg.sv
src/tlb_cfg_if.sv
src/tlb_match.sv
src/addr_tlb.sv
src/cfg_xbar.sv
src/pulp_soc.sv
test/pulp_soc_assertions.sv
test/tb_pulp_soc.sv

// File: Makefile
# Verilator build and run of the RAB testbench

VERILATOR ?= verilator
TOP       ?= tb_pulp_soc
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: test/pulp_soc_cases.txt
# W/R: config write/read  addr  data(expected rdata for R)  expected err
# H/P: h2p/p2h translation  addr  expected hit  expected addr   (all hex)
W ABCD1010 00000010 0
W ABCD1014 00000013 0
W 55AA1018 00080000 0
W 1234101C 00000001 0
R FFFF1010 00000010 0
R 0000101C 00000001 0
W 00010000 00000200 0
W 00020004 000002FF 0
W 00030008 00040000 0
W 0004000C 00000001 0
R 00050008 00040000 0
W 00002000 DEADBEEF 1
R 00003004 00000000 1
W 00001040 00000111 1
R 00001040 00000000 1
W 00000080 00000111 1
R 00001010 00000010 0
R 00000000 00000200 0
H 00012ABC 1 80002ABC
P 00500123 0 00000000
P 00250FFF 1 40050FFF
W 00000010 00000240 0
W 00000014 00000260 0
W 00000018 00090000 0
W 0000001C 00000001 0
P 00250FFF 1 40050FFF
W 0000000C 00000000 0
P 00250FFF 1 90010FFF
P 0020A000 0 00000000
H 00010000 1 80000000
H 00013FFF 1 80003FFF
H 00014000 0 00000000
P 00255555 1 90015555

// File: test/tb_pulp_soc.sv
// ****************************************
// testbench of the RAB top level
// replays the case file on config and
// translation ports and checks results
// ****************************************

module tb_pulp_soc;

  localparam int MAX_CASES = 128;

  logic        clk_i;
  logic        rst_n_i;
  logic        cfg_req_valid_i;
  logic        cfg_req_ready_o;
  logic        cfg_req_write_i;
  logic [31:0] cfg_req_addr_i;
  logic [31:0] cfg_req_wdata_i;
  logic        cfg_resp_valid_o;
  logic [31:0] cfg_resp_rdata_o;
  logic        cfg_resp_err_o;
  logic        h2p_valid_i;
  logic [31:0] h2p_addr_i;
  logic        h2p_valid_o;
  logic [31:0] h2p_addr_o;
  logic        h2p_hit_o;
  logic        p2h_valid_i;
  logic [31:0] p2h_addr_i;
  logic        p2h_valid_o;
  logic [31:0] p2h_addr_o;
  logic        p2h_hit_o;
  logic        rab_from_host_miss_irq_o;
  logic        rab_from_pulp_miss_irq_o;

  byte         op_mem [MAX_CASES];
  logic [31:0] arg_a [MAX_CASES];
  logic [31:0] arg_b [MAX_CASES];
  logic [31:0] arg_c [MAX_CASES];
  int          num_cases;
  int          cur_case;
  int          case_errors;
  int          failed;
  int          passed;
  int          cycles;
  int          cycle_limit;
  logic        file_ok;

  pulp_soc pulp_soc_inst (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // limit stays zero until the case count is known
  initial begin
    cycles = 0;
    while (!(cycle_limit > 0 && cycles > cycle_limit)) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("timeout: run did not finish within %0d cycles", cycle_limit);
    $display("SIMULATION FAILED");
    $finish;
  end

  task automatic load_cases();
    int          fd;
    int          n;
    string       line;
    byte         op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    num_cases = 0;
    fd = $fopen("test/pulp_soc_cases.txt", "r");
    file_ok = (fd != 0);
    if (fd != 0) begin
      while (!$feof(fd) && num_cases < MAX_CASES) begin
        line = "";
        if ($fgets(line, fd) != 0) begin
          n = $sscanf(line, "%c %h %h %h", op, a, b, c);
          // '#' lines describe the columns
          if (n == 4 && op != 8'h23) begin
            op_mem[num_cases] = op;
            arg_a[num_cases] = a;
            arg_b[num_cases] = b;
            arg_c[num_cases] = c;
            num_cases++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("[FAIL] case %0d %s expected %h actual %h", cur_case, name, exp, act);
      case_errors++;
    end
  endtask

  // config access entered and left at rising edge plus 10
  task automatic cfg_access(input int i);
    cfg_req_valid_i = 1'b1;
    cfg_req_write_i = (op_mem[i] == "W");
    cfg_req_addr_i  = arg_a[i];
    cfg_req_wdata_i = (op_mem[i] == "W") ? arg_b[i] : 32'h0;
    while (!cfg_req_ready_o) begin
      @(posedge clk_i);
      #10;
    end
    @(posedge clk_i);
    #10;
    cfg_req_valid_i = 1'b0;
    while (!cfg_resp_valid_o) begin
      @(posedge clk_i);
      #10;
    end
    check_val("cfg_resp_err_o", arg_c[i], 32'(cfg_resp_err_o));
    // rdata is defined for reads and error responses only
    if (op_mem[i] == "R" || arg_c[i] != 32'h0) begin
      check_val("cfg_resp_rdata_o", (op_mem[i] == "R") ? arg_b[i] : 32'h0, cfg_resp_rdata_o);
    end
  endtask

  // one translation with its result a cycle later
  task automatic translate(input int i);
    logic hit_exp;
    hit_exp = arg_b[i][0];
    if (op_mem[i] == "H") begin
      h2p_valid_i = 1'b1;
      h2p_addr_i  = arg_a[i];
    end else begin
      p2h_valid_i = 1'b1;
      p2h_addr_i  = arg_a[i];
    end
    @(posedge clk_i);
    #10;
    h2p_valid_i = 1'b0;
    p2h_valid_i = 1'b0;
    if (op_mem[i] == "H") begin
      check_val("h2p_valid_o", 32'h1, 32'(h2p_valid_o));
      check_val("h2p_hit_o", 32'(hit_exp), 32'(h2p_hit_o));
      check_val("h2p_addr_o", arg_c[i], h2p_addr_o);
      check_val("rab_from_host_miss_irq_o", 32'(!hit_exp), 32'(rab_from_host_miss_irq_o));
    end else begin
      check_val("p2h_valid_o", 32'h1, 32'(p2h_valid_o));
      check_val("p2h_hit_o", 32'(hit_exp), 32'(p2h_hit_o));
      check_val("p2h_addr_o", arg_c[i], p2h_addr_o);
      check_val("rab_from_pulp_miss_irq_o", 32'(!hit_exp), 32'(rab_from_pulp_miss_irq_o));
    end
  endtask

  initial begin
    rst_n_i         = 1'b0;
    cfg_req_valid_i = 1'b0;
    cfg_req_write_i = 1'b0;
    cfg_req_addr_i  = '0;
    cfg_req_wdata_i = '0;
    h2p_valid_i     = 1'b0;
    h2p_addr_i      = '0;
    p2h_valid_i     = 1'b0;
    p2h_addr_i      = '0;
    failed = 0;
    passed = 0;
    load_cases();
    if (!file_ok || num_cases == 0) begin
      $display("case file missing or empty");
      failed++;
    end
    cycle_limit = num_cases * 8 + 100;
    repeat (2) @(posedge clk_i);
    #10;
    rst_n_i = 1'b1;
    @(posedge clk_i);
    #10;
    for (int i = 0; i < num_cases; i++) begin
      cur_case = i;
      case_errors = 0;
      if (op_mem[i] == "W" || op_mem[i] == "R") begin
        cfg_access(i);
      end else if (op_mem[i] == "H" || op_mem[i] == "P") begin
        translate(i);
      end else begin
        $display("case %0d has an unknown operation", i);
        case_errors++;
      end
      if (case_errors == 0) begin
        $display("case %0d %c %h ok", i, op_mem[i], arg_a[i]);
        passed++;
      end else begin
        failed++;
      end
    end
    $display("%0d cases, %0d passed, %0d failed", num_cases, passed, failed);
    if (failed == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: test/pulp_soc_assertions.sv
// ****************************************
// protocol checks on the RAB top level
// config handshake and miss interrupts
// ****************************************

module pulp_soc_assertions (
  input logic clk_i,
  input logic rst_n_i,
  input logic cfg_req_valid_i,
  input logic cfg_req_ready_o,
  input logic cfg_resp_valid_o,
  input logic h2p_valid_o,
  input logic h2p_hit_o,
  input logic p2h_valid_o,
  input logic p2h_hit_o,
  input logic rab_from_host_miss_irq_o,
  input logic rab_from_pulp_miss_irq_o
);

  // response exactly two cycles after acceptance
  a_resp_latency : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (cfg_req_valid_i && cfg_req_ready_o) |=> !cfg_resp_valid_o ##1 cfg_resp_valid_o)
    else $error("config response not two cycles after acceptance");

  // one access in flight
  a_ready_low : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (cfg_req_valid_i && cfg_req_ready_o) |=> !cfg_req_ready_o)
    else $error("config ready high while an access is outstanding");

  a_host_irq : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rab_from_host_miss_irq_o |-> (h2p_valid_o && !h2p_hit_o))
    else $error("host miss irq without a missing h2p result");

  a_pulp_irq : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rab_from_pulp_miss_irq_o |-> (p2h_valid_o && !p2h_hit_o))
    else $error("pulp miss irq without a missing p2h result");

endmodule

bind pulp_soc pulp_soc_assertions pulp_soc_assertions_inst (
  .clk_i                    (clk_i),
  .rst_n_i                  (rst_n_i),
  .cfg_req_valid_i          (cfg_req_valid_i),
  .cfg_req_ready_o          (cfg_req_ready_o),
  .cfg_resp_valid_o         (cfg_resp_valid_o),
  .h2p_valid_o              (h2p_valid_o),
  .h2p_hit_o                (h2p_hit_o),
  .p2h_valid_o              (p2h_valid_o),
  .p2h_hit_o                (p2h_hit_o),
  .rab_from_host_miss_irq_o (rab_from_host_miss_irq_o),
  .rab_from_pulp_miss_irq_o (rab_from_pulp_miss_irq_o)
);

// File: src/pulp_soc.sv
// ****************************************
// RAB top level of the host/accelerator
// SoC: config crossbar plus one TLB per
// translation direction
// ****************************************

`include "pulp_consts.svh"

module pulp_soc (
  input  logic               clk_i,
  input  logic               rst_n_i,

  // host configuration port
  input  logic               cfg_req_valid_i,
  output logic               cfg_req_ready_o,
  input  logic               cfg_req_write_i,
  input  cfg_pkg::cfg_addr_t cfg_req_addr_i,
  input  cfg_pkg::cfg_data_t cfg_req_wdata_i,
  output logic               cfg_resp_valid_o,
  output cfg_pkg::cfg_data_t cfg_resp_rdata_o,
  output logic               cfg_resp_err_o,

  // host to pulp
  input  logic               h2p_valid_i,
  input  tlb_pkg::addr_t     h2p_addr_i,
  output logic               h2p_valid_o,
  output tlb_pkg::addr_t     h2p_addr_o,
  output logic               h2p_hit_o,

  // pulp to host
  input  logic               p2h_valid_i,
  input  tlb_pkg::addr_t     p2h_addr_i,
  output logic               p2h_valid_o,
  output tlb_pkg::addr_t     p2h_addr_o,
  output logic               p2h_hit_o,

  // miss interrupts
  output logic               rab_from_host_miss_irq_o,
  output logic               rab_from_pulp_miss_irq_o
);

  tlb_cfg_if p2h_cfg ();
  tlb_cfg_if h2p_cfg ();

  cfg_xbar i_cfg_xbar (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .cfg_req_valid_i  (cfg_req_valid_i),
    .cfg_req_ready_o  (cfg_req_ready_o),
    .cfg_req_write_i  (cfg_req_write_i),
    .cfg_req_addr_i   (cfg_req_addr_i),
    .cfg_req_wdata_i  (cfg_req_wdata_i),
    .cfg_resp_valid_o (cfg_resp_valid_o),
    .cfg_resp_rdata_o (cfg_resp_rdata_o),
    .cfg_resp_err_o   (cfg_resp_err_o),
    .p2h_cfg          (p2h_cfg),
    .h2p_cfg          (h2p_cfg)
  );

  // offsets 0x0000 to 0x0fff
  addr_tlb #(
    .NUM_ENTRIES (`PULP_P2H_ENTRIES)
  ) i_p2h_tlb (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .cfg        (p2h_cfg),
    .valid_i    (p2h_valid_i),
    .addr_i     (p2h_addr_i),
    .valid_o    (p2h_valid_o),
    .addr_o     (p2h_addr_o),
    .hit_o      (p2h_hit_o),
    .miss_irq_o (rab_from_pulp_miss_irq_o)
  );

  // offsets 0x1000 to 0x1fff
  addr_tlb #(
    .NUM_ENTRIES (`PULP_H2P_ENTRIES)
  ) i_h2p_tlb (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .cfg        (h2p_cfg),
    .valid_i    (h2p_valid_i),
    .addr_i     (h2p_addr_i),
    .valid_o    (h2p_valid_o),
    .addr_o     (h2p_addr_o),
    .hit_o      (h2p_hit_o),
    .miss_irq_o (rab_from_host_miss_irq_o)
  );

endmodule

// File: src/cfg_xbar.sv
// ****************************************
// configuration crossbar of the RAB
// masks and decodes host accesses, routes
// them to one TLB, one access in flight
// ****************************************

`include "pulp_consts.svh"

module cfg_xbar (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               cfg_req_valid_i,
  output logic               cfg_req_ready_o,
  input  logic               cfg_req_write_i,
  input  cfg_pkg::cfg_addr_t cfg_req_addr_i,
  input  cfg_pkg::cfg_data_t cfg_req_wdata_i,
  output logic               cfg_resp_valid_o,
  output cfg_pkg::cfg_data_t cfg_resp_rdata_o,
  output logic               cfg_resp_err_o,
  tlb_cfg_if.xbar            p2h_cfg,
  tlb_cfg_if.xbar            h2p_cfg
);

  cfg_pkg::cfg_addr_t  ofs;
  logic                accept;
  logic                sel_p2h;
  logic                sel_h2p;

  logic                ready_q;
  logic                s1_valid_q;
  logic                s1_p2h_q;
  logic                s1_h2p_q;
  logic                s2_valid_q;
  logic                s2_p2h_q;
  logic                s2_h2p_q;

  logic                write_q;
  cfg_pkg::cfg_idx_t   idx_q;
  cfg_pkg::cfg_field_e field_q;
  cfg_pkg::cfg_data_t  wdata_q;

  assign accept = cfg_req_valid_i & ready_q;

  // upper 16 bits ignored
  assign ofs     = cfg_req_addr_i & `PULP_CFG_OFS_MASK;
  assign sel_p2h = ofs < `PULP_H2P_WINDOW;
  assign sel_h2p = !sel_p2h && (ofs < 2 * `PULP_H2P_WINDOW);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ready_q    <= 1'b1;
      s1_valid_q <= 1'b0;
      s1_p2h_q   <= 1'b0;
      s1_h2p_q   <= 1'b0;
      s2_valid_q <= 1'b0;
      s2_p2h_q   <= 1'b0;
      s2_h2p_q   <= 1'b0;
    end else begin
      s1_valid_q <= accept;
      s2_valid_q <= s1_valid_q;
      s2_p2h_q   <= s1_p2h_q;
      s2_h2p_q   <= s1_h2p_q;
      if (accept) begin
        ready_q  <= 1'b0;
        s1_p2h_q <= sel_p2h;
        s1_h2p_q <= sel_h2p;
      end else if (s1_valid_q) begin
        // free again once the TLB has the request
        ready_q <= 1'b1;
      end
    end
  end

  // request payload, shared by both TLB ports
  always_ff @(posedge clk_i) begin
    if (accept) begin
      write_q <= cfg_req_write_i;
      idx_q   <= ofs[`PULP_PAGE_OFS_W-1:4];
      field_q <= cfg_pkg::cfg_field_e'(ofs[3:2]);
      wdata_q <= cfg_req_wdata_i;
    end
  end

  assign p2h_cfg.req   = s1_valid_q & s1_p2h_q;
  assign p2h_cfg.write = write_q;
  assign p2h_cfg.idx   = idx_q;
  assign p2h_cfg.field = field_q;
  assign p2h_cfg.wdata = wdata_q;

  assign h2p_cfg.req   = s1_valid_q & s1_h2p_q;
  assign h2p_cfg.write = write_q;
  assign h2p_cfg.idx   = idx_q;
  assign h2p_cfg.field = field_q;
  assign h2p_cfg.wdata = wdata_q;

  assign cfg_req_ready_o  = ready_q;
  assign cfg_resp_valid_o = s2_valid_q;

  // merge TLB answer, no window selected means decode error
  always_comb begin
    cfg_resp_rdata_o = '0;
    cfg_resp_err_o   = 1'b1;
    if (s2_p2h_q) begin
      cfg_resp_rdata_o = p2h_cfg.rdata;
      cfg_resp_err_o   = p2h_cfg.err;
    end else if (s2_h2p_q) begin
      cfg_resp_rdata_o = h2p_cfg.rdata;
      cfg_resp_err_o   = h2p_cfg.err;
    end
  end

endmodule

// File: src/addr_tlb.sv
// ****************************************
// address TLB for one RAB direction
// entry storage, config access and a
// registered one-cycle translation
// ****************************************

`include "pulp_consts.svh"

module addr_tlb #(
  parameter int unsigned NUM_ENTRIES = 4
) (
  input  logic           clk_i,
  input  logic           rst_n_i,
  tlb_cfg_if.tlb         cfg,
  input  logic           valid_i,
  input  tlb_pkg::addr_t addr_i,
  output logic           valid_o,
  output tlb_pkg::addr_t addr_o,
  output logic           hit_o,
  output logic           miss_irq_o
);

  // one extra bit so 256 entries still compare
  localparam logic [8:0] ENTRY_LIMIT = 9'(NUM_ENTRIES);

  tlb_pkg::page_t [NUM_ENTRIES-1:0] first_q;
  tlb_pkg::page_t [NUM_ENTRIES-1:0] last_q;
  tlb_pkg::page_t [NUM_ENTRIES-1:0] base_q;
  logic [NUM_ENTRIES-1:0]           valid_q;

  logic                idx_ok;
  cfg_pkg::cfg_data_t  read_word;
  cfg_pkg::cfg_data_t  rdata_q;
  logic                err_q;

  tlb_pkg::page_t      in_page;
  tlb_pkg::ofs_t       in_ofs;
  tlb_pkg::page_t      out_page;
  logic                match_hit;
  tlb_pkg::addr_t      addr_q;

  assign idx_ok = {1'b0, cfg.idx} < ENTRY_LIMIT;

  // unwritten fields read back as zero
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      first_q <= '0;
      last_q  <= '0;
      base_q  <= '0;
      valid_q <= '0;
    end else if (cfg.req && cfg.write && idx_ok) begin
      for (int unsigned i = 0; i < NUM_ENTRIES; i++) begin
        if (cfg.idx == cfg_pkg::cfg_idx_t'(i)) begin
          case (cfg.field)
            cfg_pkg::FIRST_PAGE: first_q[i] <= tlb_pkg::page_t'(cfg.wdata);
            cfg_pkg::LAST_PAGE:  last_q[i]  <= tlb_pkg::page_t'(cfg.wdata);
            cfg_pkg::BASE_PAGE:  base_q[i]  <= tlb_pkg::page_t'(cfg.wdata);
            cfg_pkg::FLAGS:      valid_q[i] <= cfg.wdata[0];
          endcase
        end
      end
    end
  end

  always_comb begin
    read_word = '0;
    for (int unsigned i = 0; i < NUM_ENTRIES; i++) begin
      if (cfg.idx == cfg_pkg::cfg_idx_t'(i)) begin
        case (cfg.field)
          cfg_pkg::FIRST_PAGE: read_word = cfg_pkg::cfg_data_t'(first_q[i]);
          cfg_pkg::LAST_PAGE:  read_word = cfg_pkg::cfg_data_t'(last_q[i]);
          cfg_pkg::BASE_PAGE:  read_word = cfg_pkg::cfg_data_t'(base_q[i]);
          cfg_pkg::FLAGS:      read_word = cfg_pkg::cfg_data_t'(valid_q[i]);
        endcase
      end
    end
  end

  // answer one cycle after req, zero data on writes and errors
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      err_q <= 1'b0;
    end else if (cfg.req) begin
      err_q <= !idx_ok;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cfg.req) begin
      rdata_q <= (idx_ok && !cfg.write) ? read_word : '0;
    end
  end

  assign cfg.rdata = rdata_q;
  assign cfg.err   = err_q;

  assign in_page = addr_i[`PULP_ADDR_W-1:`PULP_PAGE_OFS_W];
  assign in_ofs  = addr_i[`PULP_PAGE_OFS_W-1:0];

  tlb_match #(
    .NUM_ENTRIES (NUM_ENTRIES)
  ) i_match (
    .page_i  (in_page),
    .first_i (first_q),
    .last_i  (last_q),
    .base_i  (base_q),
    .valid_i (valid_q),
    .hit_o   (match_hit),
    .page_o  (out_page)
  );

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_o    <= 1'b0;
      hit_o      <= 1'b0;
      miss_irq_o <= 1'b0;
    end else begin
      valid_o    <= valid_i;
      hit_o      <= valid_i & match_hit;
      miss_irq_o <= valid_i & !match_hit;
    end
  end

  // miss leaves the address at zero
  always_ff @(posedge clk_i) begin
    addr_q <= match_hit ? {out_page, in_ofs} : '0;
  end

  assign addr_o = addr_q;

endmodule

// File: src/tlb_match.sv
// ****************************************
// TLB range compare over all entries
// lowest matching index gives the page
// ****************************************

module tlb_match #(
  parameter int unsigned NUM_ENTRIES = 4
) (
  input  tlb_pkg::page_t                   page_i,
  input  tlb_pkg::page_t [NUM_ENTRIES-1:0] first_i,
  input  tlb_pkg::page_t [NUM_ENTRIES-1:0] last_i,
  input  tlb_pkg::page_t [NUM_ENTRIES-1:0] base_i,
  input  logic [NUM_ENTRIES-1:0]           valid_i,
  output logic                             hit_o,
  output tlb_pkg::page_t                   page_o
);

  logic [NUM_ENTRIES-1:0] match;

  // inclusive page range per entry
  for (genvar i = 0; i < NUM_ENTRIES; i++) begin : gen_cmp
    assign match[i] = valid_i[i] && (page_i >= first_i[i]) && (page_i <= last_i[i]);
  end

  always_comb begin
    hit_o  = 1'b0;
    page_o = '0;
    for (int unsigned i = 0; i < NUM_ENTRIES; i++) begin
      if (match[i] && !hit_o) begin
        hit_o  = 1'b1;
        // relative page inside the range, rebased
        page_o = base_i[i] + (page_i - first_i[i]);
      end
    end
  end

endmodule

// File: src/tlb_cfg_if.sv
// ****************************************
// single config access from crossbar to
// one TLB, answered one cycle later
// ****************************************

interface tlb_cfg_if;

  // one-cycle request pulse and its payload
  logic                  req;
  logic                  write;
  cfg_pkg::cfg_idx_t     idx;
  cfg_pkg::cfg_field_e   field;
  cfg_pkg::cfg_data_t    wdata;

  // registered answer from the TLB
  cfg_pkg::cfg_data_t    rdata;
  // index beyond the entry count
  logic                  err;

  modport xbar (
    output req, write, idx, field, wdata,
    input  rdata, err
  );

  modport tlb (
    input  req, write, idx, field, wdata,
    output rdata, err
  );

endinterface

// File: src/tlb_pkg.sv
// ****************************************
// translation-side types of the RAB
// addresses split into page and offset
// ****************************************

`include "pulp_consts.svh"

package tlb_pkg;

  // full address before or after translation
  typedef logic [`PULP_ADDR_W-1:0] addr_t;

  // page number, upper address bits
  typedef logic [`PULP_ADDR_W-`PULP_PAGE_OFS_W-1:0] page_t;

  // offset inside a page, passes through untouched
  typedef logic [`PULP_PAGE_OFS_W-1:0] ofs_t;

endpackage

// File: src/cfg_pkg.sv
// ****************************************
// configuration-side types of the RAB
// ****************************************

`include "pulp_consts.svh"

package cfg_pkg;

  typedef logic [`PULP_ADDR_W-1:0] cfg_addr_t;
  typedef logic [`PULP_CFG_DW-1:0] cfg_data_t;

  // entry index, offset bits 11:4
  typedef logic [`PULP_PAGE_OFS_W-5:0] cfg_idx_t;

  // entry field, offset bits 3:2
  typedef enum logic [1:0] {
    FIRST_PAGE = 2'd0,
    LAST_PAGE  = 2'd1,
    BASE_PAGE  = 2'd2,
    FLAGS      = 2'd3
  } cfg_field_e;

endpackage

// File: src/pulp_consts.svh
// ****************************************
// remapping address block constants
// widths, page geometry, config windows
// and per-direction entry counts
// ****************************************

`ifndef PULP_CONSTS_SVH
`define PULP_CONSTS_SVH

// bus widths
`define PULP_ADDR_W 32
`define PULP_CFG_DW 32

// 4 KiB pages
`define PULP_PAGE_OFS_W 12

// config offsets only use the low 16 address bits
`define PULP_CFG_OFS_MASK 32'h0000_FFFF

// host-to-pulp window base, also the size of each window
`define PULP_H2P_WINDOW 32'h0000_1000

`define PULP_P2H_ENTRIES 8
`define PULP_H2P_ENTRIES 4

`endif
